/* src.f */
verilog/residue_pkg.sv
verilog/residue_add.sv
verilog/residue_sub.sv
verilog/residue_gen.sv
verilog/residue_add_wc.sv
verilog/residue_check.sv
verilog/residue_accum.sv
tests/residue_accum_tb.sv

/* tests/residue_accum_tb.sv */
// residue_accum_tb: self-checking testbench for the residue-protected accumulator
`timescale 1ns/1ps

module residue_accum_tb;

  import residue_pkg::*;

  // --------------------------------------------------------------------------
  // run length and limits
  // --------------------------------------------------------------------------

  localparam realtime CLK_PERIOD = 4.0;
  localparam int RESET_CYCLES = 8;
  localparam int N_SMALL = 40;
  localparam int N_LARGE = 40;
  localparam int N_DIRECTED = 20;
  localparam int N_OPS = N_SMALL + N_LARGE + N_DIRECTED;

  // every operand may take up to four cycles with its gaps, plus room for resets
  localparam int WATCHDOG_CYCLES = N_OPS * 4 + 200;

  logic  clk;
  logic  reset;
  logic  clear;
  logic  in_valid;
  data_t in_data;
  res_t  in_res;
  data_t acc_data;
  res_t  acc_res;
  logic  err;

  integer seed = 32'hf9f4d8ae;

  // model state, m_res is the true residue of m_data
  // m_off is how far the tracked residue has drifted from the truth
  data_t m_data;
  res_t  m_res;
  int    m_off;
  bit    m_res_known;
  bit    m_err;
  bit    check_en;

  residue_accum u_dut (
    .clk      (clk),
    .reset    (reset),
    .clear    (clear),
    .in_valid (in_valid),
    .in_data  (in_data),
    .in_res   (in_res),
    .acc_data (acc_data),
    .acc_res  (acc_res),
    .err      (err)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // reference model and compare
  // --------------------------------------------------------------------------

  // next accumulator value wraps modulo 2^16, the top two bits carry its residue
  function automatic logic [DATA_W+1:0] model_accumulate(input data_t acc, input data_t op);
    data_t sum;
    sum = acc + op;
    return {res_t'(sum % 3), sum};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // outputs are read at the rising edge before the DUT registers change,
  // then the model takes the same inputs the DUT is taking at this edge
  always @(posedge clk) begin : model_and_compare
    logic [DATA_W+1:0] nxt;
    bit                next_err;
    if (check_en) begin
      check_value("acc_data", acc_data, m_data);
      if (m_res_known) begin
        check_value("acc_res", acc_res, (int'(m_res) + m_off) % 3);
      end
      check_value("err", err, m_err);
    end
    if (reset) begin
      m_data      = '0;
      m_res       = RES_ZERO;
      m_off       = 0;
      m_res_known = 1'b1;
      m_err       = 1'b0;
    end else begin
      // a drifted residue in the stored state is seen one cycle after the update
      next_err = m_err | (m_res_known && m_off != 0) |
                 (in_valid && !clear && in_res == RES_ILLEGAL);
      if (clear) begin
        m_data      = '0;
        m_res       = RES_ZERO;
        m_off       = 0;
        m_res_known = 1'b1;
      end else if (in_valid) begin
        nxt    = model_accumulate(m_data, in_data);
        m_data = nxt[DATA_W-1:0];
        m_res  = nxt[DATA_W+1:DATA_W];
        if (in_res == RES_ILLEGAL) begin
          m_res_known = 1'b0;
        end else begin
          m_off = (m_off + int'(in_res) + 3 - int'(in_data % 3)) % 3;
        end
      end
      m_err = next_err;
    end
  end

  // --------------------------------------------------------------------------
  // stimulus tasks, all inputs change on the falling edge
  // --------------------------------------------------------------------------

  task automatic apply_reset();
    @(negedge clk);
    reset    = 1'b1;
    clear    = 1'b0;
    in_valid = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic send_operand(input data_t d, input res_t r);
    @(negedge clk);
    clear    = 1'b0;
    in_valid = 1'b1;
    in_data  = d;
    in_res   = r;
  endtask

  task automatic send_clear(input data_t d, input res_t r);
    @(negedge clk);
    clear    = 1'b1;
    in_valid = 1'b1;
    in_data  = d;
    in_res   = r;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      clear    = 1'b0;
      in_valid = 1'b0;
    end
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin : run_tests
    data_t op;
    int    gap;
    reset    = 1'b1;
    clear    = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    in_res   = RES_ZERO;
    check_en = 1'b0;

    // state straight out of reset before any strobe
    apply_reset();
    check_en = 1'b1;
    check_value("acc_data", acc_data, 0);
    check_value("acc_res", acc_res, 0);
    check_value("err", err, 0);
    idle_cycles(2);

    // small operands stay far below 2^16 in total, mixing back-to-back and gapped strobes
    for (int i = 0; i < N_SMALL; i++) begin
      op = data_t'($random(seed)) & 16'h03ff;
      send_operand(op, res_t'(op % 3));
      gap = ($random(seed) & 32'h3) % 3;
      if (gap > 0) begin
        idle_cycles(gap);
      end
    end
    idle_cycles(1);
    check_value("err", err, 0);

    // large operands wrap almost every time and drive the carry adjust
    for (int i = 0; i < N_LARGE; i++) begin
      op = data_t'($random(seed)) | 16'h8000;
      send_operand(op, res_t'(op % 3));
    end
    idle_cycles(1);
    check_value("acc_res", acc_res, m_res);
    check_value("err", err, 0);

    // clear wins over a strobe in the same cycle, even one with a bad residue
    send_clear(16'h1234, res_t'(16'h1234 % 3));
    idle_cycles(1);
    check_value("acc_data", acc_data, 0);
    check_value("acc_res", acc_res, 0);
    send_operand(16'h0007, res_t'(16'h0007 % 3));
    send_clear(16'h00ff, RES_ILLEGAL);
    idle_cycles(2);
    check_value("acc_data", acc_data, 0);
    check_value("err", err, 0);

    // 0x0010 is 1 modulo 3, so a residue of 2 is legal but wrong
    send_operand(16'h0101, res_t'(16'h0101 % 3));
    send_operand(16'h0010, 2'd2);
    idle_cycles(1);
    check_value("acc_data", acc_data, 16'h0111);
    check_value("err", err, 0);
    idle_cycles(1);
    check_value("err", err, 1);
    send_operand(16'h0300, res_t'(16'h0300 % 3));
    send_operand(16'hfff0, res_t'(16'hfff0 % 3));
    send_clear(16'h0000, RES_ZERO);
    idle_cycles(3);
    check_value("acc_data", acc_data, 0);
    check_value("err", err, 1);

    // an illegal operand residue sets err on the same edge as the update
    apply_reset();
    check_value("err", err, 0);
    send_operand(16'h0042, RES_ILLEGAL);
    idle_cycles(1);
    check_value("acc_data", acc_data, 16'h0042);
    check_value("err", err, 1);
    idle_cycles(2);
    check_value("err", err, 1);

    // a new reset brings everything back and correct operands run clean again
    apply_reset();
    check_value("acc_data", acc_data, 0);
    check_value("acc_res", acc_res, 0);
    check_value("err", err, 0);
    send_operand(16'hc001, res_t'(16'hc001 % 3));
    send_operand(16'h7fff, res_t'(16'h7fff % 3));
    send_operand(16'h8000, res_t'(16'h8000 % 3));
    idle_cycles(3);
    check_value("err", err, 0);

    $display("TESTS PASSED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // watchdog
  // --------------------------------------------------------------------------

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* verilog/residue_accum.sv */
// residue_accum: wrapping 16-bit accumulator with a tracked modulo-3 residue and sticky error
`timescale 1ns/1ps

module residue_accum (
  input  logic                clk,
  input  logic                reset,
  input  logic                clear,
  input  logic                in_valid,
  input  residue_pkg::data_t  in_data,
  input  residue_pkg::res_t   in_res,
  output residue_pkg::data_t  acc_data,
  output residue_pkg::res_t   acc_res,
  output logic                err
);

  import residue_pkg::*;

  // ---------------------------------------------------------------------------
  // binary datapath
  // ---------------------------------------------------------------------------

  // one extra bit on the add so the carry out is visible
  logic [DATA_W:0] sum_full;
  data_t           sum_data;
  logic            sum_carry;

  assign sum_full  = {1'b0, acc_data} + {1'b0, in_data};
  assign sum_data  = sum_full[DATA_W-1:0];
  assign sum_carry = sum_full[DATA_W];

  // ---------------------------------------------------------------------------
  // residue datapath
  // ---------------------------------------------------------------------------

  // next residue runs alongside the binary add, corrected for the
  // 2^16 that drops out when the add wraps
  res_t res_next;

  residue_add_wc #(
    .WIDTH (DATA_W)
  ) u_res_add_wc (
    .a     (acc_res),
    .b     (in_res),
    .carry (sum_carry),
    .r     (res_next)
  );

  // ---------------------------------------------------------------------------
  // stored state check
  // ---------------------------------------------------------------------------

  // the residue recomputed from the stored value is compared with the
  // tracked one every cycle, independent of any strobe
  res_t res_calc;
  logic state_mismatch;

  residue_gen #(
    .WIDTH (DATA_W)
  ) u_res_gen (
    .d (acc_data),
    .r (res_calc)
  );

  residue_check u_res_check (
    .res_calc (res_calc),
    .res_held (acc_res),
    .mismatch (state_mismatch)
  );

  // an operand residue of 3 is caught as it arrives instead of a cycle
  // later through the stored state
  // a cleared strobe is dropped, so its residue is not looked at
  logic in_res_bad;

  assign in_res_bad = in_valid & ~clear & (in_res == RES_ILLEGAL);

  // ---------------------------------------------------------------------------
  // registers
  // ---------------------------------------------------------------------------

  // clear wins over a strobe in the same cycle and zeroes both value
  // and residue, which keeps the pair consistent
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_data <= '0;
      acc_res  <= RES_ZERO;
    end else if (clear) begin
      acc_data <= '0;
      acc_res  <= RES_ZERO;
    end else if (in_valid) begin
      acc_data <= sum_data;
      acc_res  <= res_next;
    end
  end

  // sticky error, only reset brings it back down
  // clear restores consistent state but keeps the record of the fault
  always_ff @(posedge clk) begin
    if (reset) begin
      err <= 1'b0;
    end else if (state_mismatch | in_res_bad) begin
      err <= 1'b1;
    end
  end

endmodule

/* verilog/residue_add.sv */
// residue_add: combinational modulo-3 adder of two 2-bit residues
`timescale 1ns/1ps

module residue_add (
  input  residue_pkg::res_t a,
  input  residue_pkg::res_t b,
  output residue_pkg::res_t r
);

  // the nine legal combinations are listed out, which keeps the logic
  // flat and lets synthesis pick the best two-level form
  // inputs of 3 fall to the default and give a legal-width but
  // meaningless result, the checker catches that code elsewhere
  always_comb begin
    case ({a, b})
      4'b00_00: r = 2'd0;
      4'b00_01: r = 2'd1;
      4'b00_10: r = 2'd2;
      4'b01_00: r = 2'd1;
      4'b01_01: r = 2'd2;
      4'b01_10: r = 2'd0;
      4'b10_00: r = 2'd2;
      4'b10_01: r = 2'd0;
      4'b10_10: r = 2'd1;
      default:  r = 2'd0;
    endcase
  end

endmodule

/* verilog/residue_add_wc.sv */
// residue_add_wc: modulo-3 residue adder corrected for the carry out of the parent binary adder
`timescale 1ns/1ps

module residue_add_wc #(
  parameter int WIDTH = 16
) (
  input  residue_pkg::res_t a,
  input  residue_pkg::res_t b,
  input  logic              carry,
  output residue_pkg::res_t r
);

  import residue_pkg::*;

  // plain sum of the two operand residues
  res_t sum_res;

  // residue to take out when the parent adder dropped its carry
  res_t adj_res;

  residue_add u_res_add (
    .a (a),
    .b (b),
    .r (sum_res)
  );

  // a carry out means the wrapped binary sum lost 2^WIDTH, so that
  // amount has to come out of the residue as well
  // 2^WIDTH modulo 3 only depends on whether WIDTH is even or odd
  always_comb begin
    adj_res = RES_ZERO;
    if (carry) begin
      if ((WIDTH % 2) == 1) begin
        adj_res = RES_POW2_ODD;
      end else begin
        adj_res = RES_POW2_EVEN;
      end
    end
  end

  // b minus a, the adjust is the part removed
  residue_sub u_res_sub (
    .a (adj_res),
    .b (sum_res),
    .r (r)
  );

endmodule

/* verilog/residue_check.sv */
// residue_check: flags a carried residue that is illegal or disagrees with the recomputed one
`timescale 1ns/1ps

module residue_check (
  input  residue_pkg::res_t res_calc,
  input  residue_pkg::res_t res_held,
  output logic              mismatch
);

  import residue_pkg::*;

  // the two failure causes are kept as named terms so they show up
  // separately in waveforms when an error is being traced
  logic held_illegal;
  logic held_differs;

  // ---------------------------------------------------------------------------
  // stored residue checks
  // ---------------------------------------------------------------------------

  // code 3 can never come out of legal residue arithmetic, so seeing it
  // in the register means a bit flipped there or upstream
  assign held_illegal = (res_held == RES_ILLEGAL);

  // res_calc is always legal since it comes from the generator tree,
  // so any difference points at the held value or the stored data
  assign held_differs = (res_held != res_calc);

  // either cause is enough, the caller makes the flag sticky
  assign mismatch = held_illegal | held_differs;

endmodule

/* verilog/residue_gen.sv */
// residue_gen: modulo-3 residue of a vector of any width, folded through a tree of bit pairs
`timescale 1ns/1ps

module residue_gen #(
  parameter int WIDTH = 16
) (
  input  logic [WIDTH-1:0]  d,
  output residue_pkg::res_t r
);

  import residue_pkg::*;

  // ---------------------------------------------------------------------------
  // tree shape
  // ---------------------------------------------------------------------------

  // each pair of bits carries weight 4^p, and 4 is 1 modulo 3, so the
  // residue of the whole vector is the modulo-3 sum of the pair values
  localparam int NPAIRS = (WIDTH + 1) / 2;

  // leaves are padded up to a power of two so the tree stays balanced
  localparam int NLEAF = 2 ** $clog2(NPAIRS);

  // heap numbering, node 1 is the root and leaves sit at NLEAF and above
  res_t node [1:2*NLEAF-1];

  // ---------------------------------------------------------------------------
  // leaves
  // ---------------------------------------------------------------------------

  genvar p;
  generate
    for (p = 0; p < NLEAF; p++) begin : g_leaf
      if (2*p + 1 < WIDTH) begin : g_pair
        // a full pair is its own residue except that 3 folds to 0
        assign node[NLEAF+p] = (d[2*p+1:2*p] == 2'd3) ? RES_ZERO : d[2*p+1:2*p];
      end else if (2*p < WIDTH) begin : g_lone
        // an odd top bit is a pair whose upper bit is zero
        assign node[NLEAF+p] = {1'b0, d[2*p]};
      end else begin : g_pad
        assign node[NLEAF+p] = RES_ZERO;
      end
    end
  endgenerate

  // ---------------------------------------------------------------------------
  // reduction
  // ---------------------------------------------------------------------------

  genvar n;
  generate
    for (n = 1; n < NLEAF; n++) begin : g_node
      residue_add u_res_add (
        .a (node[2*n]),
        .b (node[2*n+1]),
        .r (node[n])
      );
    end
  endgenerate

  assign r = node[1];

endmodule

/* verilog/residue_pkg.sv */
// residue package with the data and residue widths, their types and the modulo-3 constants
package residue_pkg;

  // ---------------------------------------------------------------------------
  // widths
  // ---------------------------------------------------------------------------

  // accumulated numbers are one 16-bit word and wrap modulo 2^16
  localparam int DATA_W = 16;

  // a modulo-3 residue needs two bits, codes 0 to 2 are legal
  localparam int RES_W = 2;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [RES_W-1:0]  res_t;

  // ---------------------------------------------------------------------------
  // modulus constants
  // ---------------------------------------------------------------------------

  // residue of zero, used for reset, clear and padding in the generator tree
  localparam res_t RES_ZERO = 2'd0;

  // the only code a 2-bit residue can take that is not a valid value modulo 3
  localparam res_t RES_ILLEGAL = 2'd3;

  // 2^n modulo 3 alternates, 1 for even n and 2 for odd n
  localparam res_t RES_POW2_EVEN = 2'd1;
  localparam res_t RES_POW2_ODD  = 2'd2;

endpackage

/* verilog/residue_sub.sv */
// residue_sub: combinational modulo-3 subtractor giving b minus a for 2-bit residues
`timescale 1ns/1ps

module residue_sub (
  input  residue_pkg::res_t a,
  input  residue_pkg::res_t b,
  output residue_pkg::res_t r
);

  // operand order is b minus a, so a is the amount taken away
  // a negative difference wraps by adding 3 back
  // any input of 3 lands in the default arm with a legal-width result
  always_comb begin
    case ({b, a})
      4'b00_00: r = 2'd0;
      4'b00_01: r = 2'd2;
      4'b00_10: r = 2'd1;
      4'b01_00: r = 2'd1;
      4'b01_01: r = 2'd0;
      4'b01_10: r = 2'd2;
      4'b10_00: r = 2'd2;
      4'b10_01: r = 2'd1;
      4'b10_10: r = 2'd0;
      default:  r = 2'd0;
    endcase
  end

endmodule
